// File: design/cap_defines.svh
// ====================
// capability tag cache constants
// line geometry, tag-store base and bus ids
// ====================
`ifndef CAP_DEFINES_SVH
`define CAP_DEFINES_SVH

// one tag bit per 64-bit word, 256 words per line
`define CAP_LINE_W 256

`define CAP_SETS 1024	// direct mapped, one line per set

// top 16 MB of DRAM holds the tag bits that back the cache
`define CAP_TAG_BASE 32'h3F00_0000

`define CAP_CORE_NO 1	// core number carried in every transaction id
`define CAP_CHAN_ID 4	// channel number of the tag cache

`endif

// File: design/bus_pkg.sv
// ====================
// split request/response bus types
// command codes, transaction id and the two directions of a transfer
// ====================
`include "cap_defines.svh"

package bus_pkg;

	// ====================
	// commands
	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,	// bus idle
		CMD_LOAD  = 2'd1,	// read a whole line
		CMD_STORE = 2'd2	// write a whole line
	} bus_cmd_e;

	// transaction id, tranid runs 1 to 15 and skips zero on wrap
	typedef struct packed {
		logic [5:0] core;
		logic [2:0] channel;
		logic [3:0] tranid;
	} bus_tranid_t;

	// ====================
	// request, held constant from cyc rising until the ack cycle
	typedef struct packed {
		logic cyc;	// transfer in progress
		logic we;	// store when set
		bus_cmd_e cmd;
		logic [31:0] adr;	// line aligned byte address
		logic [31:0] sel;	// byte lane enables of the line
		logic [`CAP_LINE_W-1:0] dat;	// store data
		bus_tranid_t tid;
	} bus_req_t;

	// response from the memory side
	typedef struct packed {
		logic ack;	// one cycle, ends the transfer
		bus_tranid_t tid;
		logic [`CAP_LINE_W-1:0] dat;	// load data
	} bus_resp_t;

endpackage

// File: design/cap_pkg.sv
// ====================
// capability tag cache types
// address views, directory fields and controller states
// ====================
`include "cap_defines.svh"

package cap_pkg;

	typedef logic [$clog2(`CAP_SETS)-1:0] cap_index_t;	// directory set number
	typedef logic [10:0] cap_dtag_t;	// directory tag, address bits 31..21

	// data view of an address, one tag bit per 8 bytes
	typedef struct packed {
		cap_dtag_t tag;
		cap_index_t index;	// set holding the line of tags
		logic [7:0] word;	// tag bit within the line
		logic [2:0] byte_ofs;
	} cap_data_adr_t;

	// tag-store view, one line of tag store is 32 bytes
	// line_hi and index together give the DRAM line number adr[29:11]
	typedef struct packed {
		logic [7:0] area;	// 8'h3F inside the tag store
		logic [8:0] line_hi;	// directory tag is 2'b01 followed by this
		cap_index_t index;
		logic [4:0] byte_ofs;
	} cap_ts_adr_t;

	// the same 32-bit address read both ways
	typedef union packed {
		cap_data_adr_t data;
		cap_ts_adr_t ts;
	} cap_addr_u;

	// ====================
	typedef enum logic [2:0] {
		IDLE,	// lookups, tag updates and invalidations
		DUMP,	// issue the write-back of a modified line
		DUMP_ACK,
		LOAD,	// issue the line fill
		LOAD_ACK
	} cap_state_e;

endpackage

// File: design/cap_line_ram.sv
// ====================
// line memory of the tag cache
// one read port and one write port, write data forwarded to a read of the same line
// ====================
`timescale 1ns/100ps
`include "cap_defines.svh"

module cap_line_ram (
	input logic clk,
	input cap_pkg::cap_index_t rd_index,
	output logic [`CAP_LINE_W-1:0] rd_data,
	input logic wr_en,
	input cap_pkg::cap_index_t wr_index,
	input logic [`CAP_LINE_W-1:0] wr_data
);

	logic [`CAP_LINE_W-1:0] mem [`CAP_SETS];	// block RAM style, no reset

	// write port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_index] <= wr_data;
	end

	// read port registers the line of rd_index at every edge
	// a write to that same line in the same edge shows up at once, so a
	// tag update or a fill is visible in the cycle right after it
	always_ff @(posedge clk) begin
		if (wr_en && wr_index == rd_index)
			rd_data <= wr_data;	// write first
		else
			rd_data <= mem[rd_index];
	end

endmodule

// File: design/cap_tag_dir.sv
// ====================
// direct-mapped directory of the tag cache
// stored tag per set plus valid and modified bits, one lookup and one update port
// ====================
`timescale 1ns/100ps
`include "cap_defines.svh"

module cap_tag_dir (
	input logic clk,
	input logic rst,
	input cap_pkg::cap_index_t lk_index,	// lookup port
	input cap_pkg::cap_dtag_t lk_tag,
	output logic ihit_raw,	// valid and tag match, state not included
	output logic mod,	// set holds a modified line
	output cap_pkg::cap_dtag_t victim_tag,	// tag of the line held in the set
	input logic fill,	// update port strobes
	input logic set_mod,
	input logic clr_mod,
	input logic inval,
	input cap_pkg::cap_index_t up_index,
	input cap_pkg::cap_dtag_t up_tag
);

	cap_pkg::cap_dtag_t tags [`CAP_SETS];	// only meaningful where valid is set
	logic [`CAP_SETS-1:0] valid;
	logic [`CAP_SETS-1:0] modified;
	logic inval_match;

	// lookup is combinational so a miss is seen in the same cycle
	assign ihit_raw = valid[lk_index] && tags[lk_index] == lk_tag;
	assign mod = modified[lk_index];
	assign victim_tag = tags[lk_index];

	// the core rewrote tag store, drop the copy only if it is that line
	assign inval_match = inval && tags[up_index] == up_tag;

	always_ff @(posedge clk) begin
		if (fill)
			tags[up_index] <= up_tag;
	end

	// ====================
	// valid and modified state
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
			modified <= '0;
		end else begin
			if (fill) begin
				valid[up_index] <= 1'b1;
				modified[up_index] <= 1'b0;	// fresh line equals memory
			end
			if (set_mod)
				modified[up_index] <= 1'b1;
			if (clr_mod)
				modified[up_index] <= 1'b0;	// write-back in flight
			// pending updates of the old copy are superseded by the core's write
			if (inval_match) begin
				valid[up_index] <= 1'b0;
				modified[up_index] <= 1'b0;
			end
		end
	end

endmodule

// File: design/cap_cache.sv
// ====================
// tag cache controller
// lookup, tag update, invalidation, write-back and line fill over the bus
// ====================
`timescale 1ns/100ps
`include "cap_defines.svh"

module cap_cache (
	input logic clk,
	input logic rst,
	input logic [31:0] adr,	// held by the core until hit
	input logic wr,	// any write by the core
	input logic wr_tag,	// capability store
	input logic load_tags,	// read a 64-bit slice of tags
	input logic tagi,
	output logic hit,
	output logic tago,
	output logic [63:0] tagso,
	output bus_pkg::bus_req_t req,
	input bus_pkg::bus_resp_t resp,
	output cap_pkg::cap_index_t lk_index,	// directory lookup
	output cap_pkg::cap_dtag_t lk_tag,
	input logic ihit_raw,
	input logic mod,
	input cap_pkg::cap_dtag_t victim_tag,
	output logic fill,	// directory update
	output logic set_mod,
	output logic clr_mod,
	output logic inval,
	output cap_pkg::cap_index_t up_index,
	output cap_pkg::cap_dtag_t up_tag,
	output cap_pkg::cap_index_t rd_index,	// line RAM
	input logic [`CAP_LINE_W-1:0] rd_data,
	output logic wr_en,
	output cap_pkg::cap_index_t wr_index,
	output logic [`CAP_LINE_W-1:0] wr_data
);

	cap_pkg::cap_addr_u a;
	cap_pkg::cap_state_e state;
	bus_pkg::bus_tranid_t tid;	// id of the next command
	logic [31:0] adr_q;	// adr at the previous edge
	logic same_adr;
	logic is_dram, is_io, is_tag_area;
	logic ihit, pend;
	logic upd_go, inv_go, miss;
	logic [`CAP_LINE_W-1:0] merged;
	logic [31:0] victim_adr, load_adr;

	function automatic logic [3:0] next_tranid(input logic [3:0] t);
		return (t == 4'd15) ? 4'd1 : t + 4'd1;	// zero is never used
	endfunction

	// ====================
	// address decode
	assign a = adr;
	assign is_dram = adr[31:30] == 2'b01;
	assign is_io = !is_dram;	// I/O and anything else outside DRAM, tag always zero
	assign is_tag_area = a.ts.area == 8'h3F;	// backing store of this cache
	assign same_adr = adr == adr_q;

	assign lk_index = a.data.index;
	assign lk_tag = a.data.tag;
	assign rd_index = a.data.index;	// line of the set is always on rd_data
	assign ihit = is_io || (ihit_raw && state == cap_pkg::IDLE);

	// tag bit of the addressed word and its 64-bit group
	assign tago = is_io ? 1'b0 : rd_data[a.data.word];
	assign tagso = (is_io || !load_tags) ? 64'd0 : rd_data[{a.data.word[7:6], 6'd0} +: 64];

	// line with the addressed bit replaced by tagi
	always_comb begin
		merged = rd_data;
		merged[a.data.word] = tagi;
	end

	// core requests act only while hit belongs to the current adr
	assign upd_go = hit && same_adr && wr_tag && state == cap_pkg::IDLE;
	assign inv_go = hit && same_adr && wr && !wr_tag && is_tag_area &&
		state == cap_pkg::IDLE;
	assign miss = state == cap_pkg::IDLE && is_dram && !ihit_raw;

	// ====================
	// directory and RAM control
	assign fill = state == cap_pkg::LOAD_ACK && resp.ack;	// line arrives on the ack edge
	assign set_mod = upd_go;
	assign clr_mod = state == cap_pkg::DUMP;
	assign inval = inv_go;
	assign up_index = inv_go ? a.ts.index : a.data.index;
	assign up_tag = inv_go ? {2'b01, a.ts.line_hi} : a.data.tag;	// DRAM tags start 01

	assign wr_en = upd_go || fill;
	assign wr_index = a.data.index;
	assign wr_data = fill ? resp.dat : merged;

	// tag-store line of the line being replaced and of the missing line
	assign victim_adr = `CAP_TAG_BASE + {8'h00, victim_tag[8:0], a.data.index, 5'd0};
	assign load_adr = `CAP_TAG_BASE + {8'h00, adr[29:11], 5'd0};

	always_ff @(posedge clk)
		adr_q <= adr;

	// hit needs the lookup to pass at two edges in a row with adr unchanged
	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			hit <= 1'b0;
		end else begin
			pend <= ihit;
			hit <= ihit && pend && same_adr;
		end
	end

	// ====================
	// miss sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cap_pkg::IDLE;
			req <= '0;
			tid.core <= 6'(`CAP_CORE_NO);
			tid.channel <= 3'(`CAP_CHAN_ID);
			tid.tranid <= 4'd1;
		end else begin
			case (state)
			cap_pkg::IDLE:
				if (miss)
					state <= mod ? cap_pkg::DUMP : cap_pkg::LOAD;	// dirty victim goes out first
			cap_pkg::DUMP: begin
				req.cyc <= 1'b1;
				req.we <= 1'b1;
				req.cmd <= bus_pkg::CMD_STORE;
				req.adr <= victim_adr;
				req.sel <= '1;
				req.dat <= rd_data;	// victim line, read address follows adr
				req.tid <= tid;
				tid.tranid <= next_tranid(tid.tranid);
				state <= cap_pkg::DUMP_ACK;
			end
			cap_pkg::DUMP_ACK:
				if (resp.ack) begin
					req.cyc <= 1'b0;
					req.we <= 1'b0;
					req.cmd <= bus_pkg::CMD_NONE;
					state <= cap_pkg::LOAD;
				end
			cap_pkg::LOAD: begin
				req.cyc <= 1'b1;
				req.we <= 1'b0;
				req.cmd <= bus_pkg::CMD_LOAD;
				req.adr <= load_adr;
				req.sel <= '1;
				req.tid <= tid;
				tid.tranid <= next_tranid(tid.tranid);
				state <= cap_pkg::LOAD_ACK;
			end
			cap_pkg::LOAD_ACK:
				if (resp.ack) begin	// fill strobes fire on this edge
					req.cyc <= 1'b0;
					req.cmd <= bus_pkg::CMD_NONE;
					state <= cap_pkg::IDLE;
				end
			default:
				state <= cap_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: design/cap_tag_unit.sv
// ====================
// capability tag unit
// controller, directory and line memory of the tag cache
// ====================
`timescale 1ns/100ps
`include "cap_defines.svh"

module cap_tag_unit (
	input logic clk,
	input logic rst,
	input logic [31:0] adr,
	input logic wr,
	input logic wr_tag,
	input logic load_tags,
	input logic tagi,
	output logic hit,
	output logic tago,
	output logic [63:0] tagso,
	output bus_pkg::bus_req_t req,
	input bus_pkg::bus_resp_t resp
);

	// directory lookup and update
	cap_pkg::cap_index_t lk_index, up_index;
	cap_pkg::cap_dtag_t lk_tag, up_tag, victim_tag;
	logic ihit_raw, mod;
	logic fill, set_mod, clr_mod, inval;

	// line memory
	cap_pkg::cap_index_t rd_index, wr_index;
	logic [`CAP_LINE_W-1:0] rd_data, wr_data;
	logic wr_en;

	cap_cache cap_cache_i (
		.clk, .rst, .adr, .wr, .wr_tag, .load_tags, .tagi,
		.hit, .tago, .tagso, .req, .resp,
		.lk_index, .lk_tag, .ihit_raw, .mod, .victim_tag,
		.fill, .set_mod, .clr_mod, .inval, .up_index, .up_tag,
		.rd_index, .rd_data, .wr_en, .wr_index, .wr_data
	);

	cap_tag_dir cap_tag_dir_i (
		.clk, .rst, .lk_index, .lk_tag, .ihit_raw, .mod, .victim_tag,
		.fill, .set_mod, .clr_mod, .inval, .up_index, .up_tag
	);

	cap_line_ram cap_line_ram_i (
		.clk, .rd_index, .rd_data, .wr_en, .wr_index, .wr_data
	);

endmodule

// File: sim/tb_tag_store.sv
// ====================
// bus memory model behind the tag cache
// line store with a random ack delay of 1 to 4 cycles
// ====================
`timescale 1ns/100ps
`include "cap_defines.svh"

module tb_tag_store (
	input logic clk,
	input logic rst,
	input bus_pkg::bus_req_t req,
	output bus_pkg::bus_resp_t resp
);

	logic [`CAP_LINE_W-1:0] lines [logic [31:0]];	// only lines that were stored
	integer seed = 39;
	logic busy;	// a request is being served
	integer wait_cnt;	// cycles left until the ack

	initial resp = '0;

	// a line never written reads as eight copies of its own address
	function automatic logic [`CAP_LINE_W-1:0] read_line(input logic [31:0] a);
		if (lines.exists(a))
			return lines[a];
		return {8{a}};
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			wait_cnt <= 0;
			resp.ack <= 1'b0;
		end else begin
			resp.ack <= 1'b0;	// ack lasts one cycle
			// the ack cycle still shows cyc high, so it starts nothing new
			if (!busy && req.cyc && !resp.ack) begin
				busy <= 1'b1;
				wait_cnt <= 1 + ($random(seed) & 3);
			end else if (busy) begin
				if (wait_cnt == 1) begin
					if (req.we)
						lines[req.adr] = req.dat;
					else
						resp.dat <= read_line(req.adr);
					resp.tid <= req.tid;
					resp.ack <= 1'b1;
					busy <= 1'b0;
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
		end
	end

endmodule

// File: sim/cap_tag_unit_tb.sv
// ====================
// testbench of the capability tag unit
// table of lookups, tag updates and tag-store writes, checked against the bus traffic
// ====================
`timescale 1ns/100ps
`include "cap_defines.svh"

module cap_tag_unit_tb;

	typedef enum logic [1:0] {OP_RD, OP_LT, OP_WT, OP_WR} op_e;	// lookup, load_tags, cap store, write

	typedef struct packed {
		op_e op;
		logic [31:0] adr;
		logic tagi;
		logic [63:0] exp;	// tago in bit 0, or tagso
		logic [31:0] st_adr;	// expected write-back address, zero for none
		logic [`CAP_LINE_W-1:0] st_dat;
		logic ld;	// a line fill is expected
	} entry_t;

	logic clk, rst, wr, wr_tag, load_tags, tagi, hit, tago;
	logic [31:0] adr;
	logic [63:0] tagso;
	bus_pkg::bus_req_t req, held;
	bus_pkg::bus_resp_t resp;
	entry_t table_q[$];
	bus_pkg::bus_req_t mon_q[$];	// every command seen on the bus
	logic [`CAP_LINE_W-1:0] ref_mem [logic [31:0]];	// tag lines as the core should see them
	logic cyc_q;
	logic [3:0] exp_tranid;
	int val_errs = 0, bus_errs = 0, mon_errs = 0, cycles = 0, limit = 0;

	cap_tag_unit cap_tag_unit_i (.clk, .rst, .adr, .wr, .wr_tag, .load_tags, .tagi,
		.hit, .tago, .tagso, .req, .resp);
	tb_tag_store tb_tag_store (.clk, .rst, .req, .resp);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// expected values from the address map
	function automatic logic in_dram(input logic [31:0] a);
		return a[31:30] == 2'b01;
	endfunction

	function automatic logic [31:0] ts_line(input logic [31:0] a);
		return `CAP_TAG_BASE + (32'(a[29:11]) << 5);	// 32 bytes of tag store per DRAM line
	endfunction

	function automatic logic [`CAP_LINE_W-1:0] ref_line(input logic [31:0] a);
		logic [31:0] t;
		t = ts_line(a);
		if (ref_mem.exists(t))
			return ref_mem[t];
		return {8{t}};	// memory fill pattern
	endfunction

	function automatic logic cur_bit(input logic [31:0] a);
		logic [`CAP_LINE_W-1:0] line;
		line = ref_line(a);
		return line[a[10:3]];
	endfunction

	function automatic logic [31:0] with_tag(input logic [31:0] a, input cap_pkg::cap_dtag_t t);
		cap_pkg::cap_addr_u u;
		u = a;
		u.data.tag = t;	// same set, other line
		return u;
	endfunction

	function automatic bus_pkg::bus_tranid_t expected_tid(input logic [3:0] t);
		bus_pkg::bus_tranid_t id;
		id.core = 6'(`CAP_CORE_NO);
		id.channel = 3'(`CAP_CHAN_ID);
		id.tranid = t;
		return id;
	endfunction

	// ====================
	// stimulus table
	task automatic add_entry(input op_e op, input logic [31:0] a, input logic ti,
		input logic [31:0] victim, input logic ld);
		entry_t e;
		logic [`CAP_LINE_W-1:0] line;
		line = ref_line(a);
		e.op = op;
		e.adr = a;
		e.tagi = ti;
		e.ld = ld;
		e.exp = '0;	// I/O and tag-store addresses read zero
		if (in_dram(a))
			e.exp = (op == OP_LT) ? line[a[10:9] * 64 +: 64] : {63'd0, line[a[10:3]]};
		e.st_adr = (victim == 32'd0) ? 32'd0 : ts_line(victim);
		e.st_dat = ref_line(victim);
		if (op == OP_WT) begin
			line[a[10:3]] = ti;
			ref_mem[ts_line(a)] = line;
		end
		table_q.push_back(e);
	endtask

	task automatic build_table();
		logic [31:0] a_lo, a_cl;
		a_lo = 32'h4000_0840;	// set 1, pattern bit 0
		a_cl = 32'h4000_0828;	// set 1, pattern bit 1
		add_entry(OP_RD, 32'hFEC0_0000, 1'b0, 32'd0, 1'b0);
		add_entry(OP_LT, 32'hFEC0_1238, 1'b0, 32'd0, 1'b0);
		add_entry(OP_RD, a_lo, 1'b0, 32'd0, 1'b1);	// cold miss
		add_entry(OP_LT, a_lo, 1'b0, 32'd0, 1'b0);
		add_entry(OP_WT, a_lo, !cur_bit(a_lo), 32'd0, 1'b0);	// sets the bit
		add_entry(OP_RD, a_lo, 1'b0, 32'd0, 1'b0);
		add_entry(OP_RD, a_lo + 32'd8, 1'b0, 32'd0, 1'b0);	// neighbor keeps its pattern
		add_entry(OP_WT, a_cl, !cur_bit(a_cl), 32'd0, 1'b0);	// clears the bit
		add_entry(OP_WT, a_cl, cur_bit(a_cl), 32'd0, 1'b0);	// same update again
		add_entry(OP_RD, a_cl, 1'b0, 32'd0, 1'b0);
		add_entry(OP_LT, a_lo, 1'b0, 32'd0, 1'b0);
		add_entry(OP_RD, with_tag(a_lo, 11'h201), 1'b0, a_lo, 1'b1);	// evicts the dirty line
		add_entry(OP_RD, a_lo, 1'b0, 32'd0, 1'b1);	// comes back from memory
		add_entry(OP_WR, ts_line(a_lo), 1'b0, 32'd0, 1'b0);	// drops the cached copy
		add_entry(OP_RD, a_lo, 1'b0, 32'd0, 1'b1);
		add_entry(OP_WR, ts_line(with_tag(a_lo, 11'h208)), 1'b0, 32'd0, 1'b0);	// not cached
		add_entry(OP_LT, a_lo, 1'b0, 32'd0, 1'b0);
		for (int i = 0; i < 12; i++)	// clean misses in set 2, the tranid wraps
			add_entry(OP_RD, with_tag(32'h4000_1000 + 32'(i) * 24, 11'(12'h200 + i)),
				1'b0, 32'd0, 1'b1);
	endtask

	task automatic compare_cmd(input int n, input bus_pkg::bus_req_t r,
		input bus_pkg::bus_cmd_e cmd, input logic [31:0] a);
		logic exp_we;
		exp_we = cmd == bus_pkg::CMD_STORE;	// only a write-back writes memory
		if (r.cmd !== cmd) begin
			$display("Fail req.cmd: entry %0d got %h expected %h", n, r.cmd, cmd);
			bus_errs++;
		end
		if (r.adr !== a) begin
			$display("Fail req.adr: entry %0d got %h expected %h", n, r.adr, a);
			bus_errs++;
		end
		if (r.we !== exp_we) begin
			$display("Fail req.we: entry %0d got %h expected %h", n, r.we, exp_we);
			bus_errs++;
		end
		if (r.sel !== 32'hFFFF_FFFF) begin	// every transfer moves a whole line
			$display("Fail req.sel: entry %0d got %h expected %h", n, r.sel,
				32'hFFFF_FFFF);
			bus_errs++;
		end
	endtask

	// hold the request until hit, check it, then one cycle with the strobes low
	task automatic run_entry(input int n, input entry_t e);
		int start, idx;
		start = mon_q.size();
		@(posedge clk);
		adr <= e.adr;
		wr <= e.op == OP_WT || e.op == OP_WR;
		wr_tag <= e.op == OP_WT;
		load_tags <= e.op == OP_LT;
		tagi <= e.tagi;
		@(posedge clk);	// hit of the previous adr is gone by now
		@(negedge clk);
		while (!hit)
			@(negedge clk);
		if (e.op == OP_RD && tago !== e.exp[0]) begin
			$display("Fail tago: entry %0d got %h expected %h", n, tago, e.exp[0]);
			val_errs++;
		end
		if (e.op == OP_LT && tagso !== e.exp) begin
			$display("Fail tagso: entry %0d got %h expected %h", n, tagso, e.exp);
			val_errs++;
		end
		idx = start;
		if (mon_q.size() - start != int'(e.st_adr != 32'd0) + int'(e.ld)) begin
			$display("entry %0d saw %0d bus commands, a different number was expected",
				n, mon_q.size() - start);
			bus_errs++;
		end else begin
			if (e.st_adr != 32'd0) begin
				compare_cmd(n, mon_q[idx], bus_pkg::CMD_STORE, e.st_adr);
				if (mon_q[idx].dat !== e.st_dat) begin
					$display("Fail req.dat: entry %0d got %h expected %h", n,
						mon_q[idx].dat, e.st_dat);
					bus_errs++;
				end
				idx++;
			end
			if (e.ld)
				compare_cmd(n, mon_q[idx], bus_pkg::CMD_LOAD, ts_line(e.adr));
		end
		@(posedge clk);
		wr <= 1'b0;
		wr_tag <= 1'b0;
		load_tags <= 1'b0;
	endtask

	// ====================
	// bus monitor, samples mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			cyc_q = 1'b0;
			exp_tranid = 4'd1;
		end else begin
			if (req.cyc && !cyc_q) begin
				mon_q.push_back(req);
				held = req;
				if (req.tid !== expected_tid(exp_tranid)) begin
					$display("Fail req.tid: got %h expected %h", req.tid,
						expected_tid(exp_tranid));
					mon_errs++;
				end
				exp_tranid = (exp_tranid == 4'd15) ? 4'd1 : exp_tranid + 4'd1;
			end else if (req.cyc && req !== held) begin
				$display("bus request changed before its ack at %0t", $time);
				mon_errs++;
			end
			cyc_q = req.cyc;
		end
	end

	always @(posedge clk)
		cycles <= cycles + 1;

	initial begin
		wait (limit > 0 && cycles >= limit);
		$display("timeout after %0d cycles waiting for hit", cycles);
		$display("errors: %0d value, %0d bus, %0d monitor", val_errs, bus_errs, mon_errs);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		rst = 1'b1;
		adr = 32'hFEC0_0000;
		wr = 1'b0;
		wr_tag = 1'b0;
		load_tags = 1'b0;
		tagi = 1'b0;
		build_table();
		limit = table_q.size() * 40;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		foreach (table_q[i])
			run_entry(i, table_q[i]);
		$display("errors: %0d value, %0d bus, %0d monitor", val_errs, bus_errs, mon_errs);
		if (val_errs + bus_errs + mon_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: src.f
+incdir+design
design/bus_pkg.sv
design/cap_pkg.sv
design/cap_line_ram.sv
design/cap_tag_dir.sv
design/cap_cache.sv
design/cap_tag_unit.sv
sim/tb_tag_store.sv
sim/cap_tag_unit_tb.sv
